// File: common/xbit_cfg_pkg.sv
// Fixed cache geometry; changing a value here changes every struct and module built on it

package xbit_cfg_pkg;

  // Row addressing within one bank
  localparam int INDEX_W = 5;
  localparam int ROWS    = 32;

  // Entry layout inside a row
  localparam int ENTRY_W = 2;
  localparam int ENTRIES = 16;
  localparam int SLOT_W  = 4;

  // A fill writes half a row at once
  localparam int HALF_W  = 16;

  // Row data width before parity
  localparam int ROW_W   = 32;

  // Stored width, one parity bit above each data byte
  localparam int PROW_W  = 36;

endpackage

// File: common/xbit_types_pkg.sv
// Struct layouts follow the fixed geometry of the configuration package and pack en as the MSB

package xbit_types_pkg;

  import xbit_cfg_pkg::*;

  // One row seen as single entries or as the two fill halves
  typedef union packed {
    logic [ENTRIES-1:0][ENTRY_W-1:0]      entry;
    logic [ROW_W/HALF_W-1:0][HALF_W-1:0]  half;
  } xbit_row_u;

  typedef struct packed {
    logic               en;
    logic               odd;   // Bank select
    logic [INDEX_W-1:0] index;
    logic [SLOT_W-1:0]  slot;
  } xbit_lookup_req_t;

  typedef struct packed {
    logic               en;
    logic               odd;
    logic [INDEX_W-1:0] index;
    logic [SLOT_W-1:0]  slot;
    logic [ENTRY_W-1:0] value;
  } xbit_update_req_t;

  typedef struct packed {
    logic               en;
    logic               odd;
    logic [INDEX_W-1:0] index;
    logic               half;
    logic [HALF_W-1:0]  data;  // Entry 8h+k sits at bits 2k+1:2k
  } xbit_fill_req_t;

  typedef struct packed {
    logic               en;
    logic               odd;
    logic [INDEX_W-1:0] index;
    xbit_row_u          row;
  } xbit_wr_cmd_t;

  typedef struct packed {
    logic               valid;
    logic [ENTRY_W-1:0] value;
    logic               parity_err;
  } xbit_lookup_rsp_t;

endpackage

// File: xbit_bank/xbit_bank_ram.sv
// Contents have no reset and stay undefined until written, and the rmw read port is not checked
`timescale 1ns/1ps

module xbit_bank_ram (
  input  logic                         clk,
  input  logic                         side,
  input  logic [xbit_cfg_pkg::INDEX_W-1:0] rd0_index,
  input  logic [xbit_cfg_pkg::INDEX_W-1:0] rd1_index,
  input  logic [xbit_cfg_pkg::INDEX_W-1:0] rmw_index,
  output xbit_types_pkg::xbit_row_u    rd0_row,
  output xbit_types_pkg::xbit_row_u    rd1_row,
  output xbit_types_pkg::xbit_row_u    rmw_row,
  output logic                         rd0_perr,
  output logic                         rd1_perr,
  input  xbit_types_pkg::xbit_wr_cmd_t wr
);

  import xbit_cfg_pkg::*;
  import xbit_types_pkg::*;

  logic [PROW_W-1:0] mem [ROWS];

  // Each byte gets an even parity bit stored just above it
  function automatic logic [PROW_W-1:0] encode(input xbit_row_u row);
    logic [PROW_W-1:0] word;
    logic [ROW_W-1:0]  data;
    data = row;
    for (int b = 0; b < ROW_W / 8; b++) begin
      word[9*b +: 8] = data[8*b +: 8];
      word[9*b + 8]  = ^data[8*b +: 8];
    end
    return word;
  endfunction

  function automatic xbit_row_u strip(input logic [PROW_W-1:0] word);
    logic [ROW_W-1:0] data;
    for (int b = 0; b < ROW_W / 8; b++) begin
      data[8*b +: 8] = word[9*b +: 8];
    end
    return data;
  endfunction

  // A clean byte and its parity bit XOR to zero
  function automatic logic check(input logic [PROW_W-1:0] word);
    logic err;
    err = 1'b0;
    for (int b = 0; b < ROW_W / 8; b++) begin
      err = err | (^word[9*b +: 9]);
    end
    return err;
  endfunction

  assign rd0_row  = strip(mem[rd0_index]);
  assign rd1_row  = strip(mem[rd1_index]);
  assign rmw_row  = strip(mem[rmw_index]);
  assign rd0_perr = check(mem[rd0_index]);
  assign rd1_perr = check(mem[rd1_index]);

  always_ff @(posedge clk) begin
    if (wr.en && (wr.odd == side)) begin
      mem[wr.index] <= encode(wr.row);  // Only the bank named by odd takes the write
    end
  end

endmodule

// File: hdl/xbit_req_stage.sv
// Only the enables are reset, so address and data fields hold stale values after reset
`timescale 1ns/1ps

module xbit_req_stage (
  input  logic                             clk,
  input  logic                             rst,
  input  xbit_types_pkg::xbit_lookup_req_t lookup0,
  input  xbit_types_pkg::xbit_lookup_req_t lookup1,
  input  xbit_types_pkg::xbit_update_req_t update,
  input  xbit_types_pkg::xbit_fill_req_t   fill,
  output xbit_types_pkg::xbit_lookup_req_t lookup0_q,
  output xbit_types_pkg::xbit_lookup_req_t lookup1_q,
  output xbit_types_pkg::xbit_update_req_t update_q,
  output xbit_types_pkg::xbit_fill_req_t   fill_q
);

  // These registers address the arrays directly in the next cycle
  always_ff @(posedge clk) begin
    lookup0_q <= lookup0;
    lookup1_q <= lookup1;
    update_q  <= update;
    fill_q    <= fill;

    if (rst) begin
      lookup0_q.en <= 1'b0;
      lookup1_q.en <= 1'b0;
      update_q.en  <= 1'b0;
      fill_q.en    <= 1'b0;
    end
  end

endmodule

// File: hdl/xbit_merge_stage.sv
// Assumes update and fill are never enabled in the same cycle, a fill takes priority if they are
`timescale 1ns/1ps

module xbit_merge_stage (
  input  xbit_types_pkg::xbit_update_req_t update_q,
  input  xbit_types_pkg::xbit_fill_req_t   fill_q,
  input  xbit_types_pkg::xbit_row_u        even_row,
  input  xbit_types_pkg::xbit_row_u        odd_row,
  output logic [xbit_cfg_pkg::INDEX_W-1:0] rmw_index,
  output xbit_types_pkg::xbit_wr_cmd_t     wr
);

  import xbit_cfg_pkg::*;
  import xbit_types_pkg::*;

  logic               sel_odd;
  logic [INDEX_W-1:0] sel_index;
  xbit_row_u          cur_row;
  xbit_row_u          new_row;

  // The enabled request names the row to read back
  always_comb begin
    if (fill_q.en) begin
      sel_odd   = fill_q.odd;
      sel_index = fill_q.index;
    end else begin
      sel_odd   = update_q.odd;
      sel_index = update_q.index;
    end
  end

  assign rmw_index = sel_index;
  assign cur_row   = sel_odd ? odd_row : even_row;

  always_comb begin
    new_row = cur_row;
    if (fill_q.en) begin
      new_row.half[fill_q.half] = fill_q.data;  // Other half is kept
    end else begin
      new_row.entry[update_q.slot] = update_q.value;
    end
  end

  always_comb begin
    wr.en    = fill_q.en | update_q.en;
    wr.odd   = sel_odd;
    wr.index = sel_index;
    wr.row   = new_row;
  end

endmodule

// File: hdl/xbit_read_stage.sv
// Value is only meaningful while valid is high, the parity flag is forced low otherwise
`timescale 1ns/1ps

module xbit_read_stage (
  input  xbit_types_pkg::xbit_lookup_req_t lookup0_q,
  input  xbit_types_pkg::xbit_lookup_req_t lookup1_q,
  input  xbit_types_pkg::xbit_row_u        even0_row,
  input  xbit_types_pkg::xbit_row_u        odd0_row,
  input  xbit_types_pkg::xbit_row_u        even1_row,
  input  xbit_types_pkg::xbit_row_u        odd1_row,
  input  logic                             even0_perr,
  input  logic                             odd0_perr,
  input  logic                             even1_perr,
  input  logic                             odd1_perr,
  output xbit_types_pkg::xbit_lookup_rsp_t rsp0,
  output xbit_types_pkg::xbit_lookup_rsp_t rsp1
);

  import xbit_types_pkg::*;

  // Both banks are read every cycle and odd picks the one that counts
  function automatic xbit_lookup_rsp_t pick(input xbit_lookup_req_t req,
                                            input xbit_row_u        even_row,
                                            input xbit_row_u        odd_row,
                                            input logic             even_perr,
                                            input logic             odd_perr);
    xbit_lookup_rsp_t rsp;
    xbit_row_u        row;
    row            = req.odd ? odd_row : even_row;
    rsp.valid      = req.en;
    rsp.value      = row.entry[req.slot];
    rsp.parity_err = req.en & (req.odd ? odd_perr : even_perr);
    return rsp;
  endfunction

  assign rsp0 = pick(lookup0_q, even0_row, odd0_row, even0_perr, odd0_perr);
  assign rsp1 = pick(lookup1_q, even1_row, odd1_row, even1_perr, odd1_perr);

endmodule

// File: hdl/xbit_store_top.sv
// One-cycle lookup latency, writes land one edge after the request, update and fill are exclusive
`timescale 1ns/1ps

module xbit_store_top (
  input  logic                             clk,
  input  logic                             rst,
  input  xbit_types_pkg::xbit_lookup_req_t lookup0,
  input  xbit_types_pkg::xbit_lookup_req_t lookup1,
  input  xbit_types_pkg::xbit_update_req_t update,
  input  xbit_types_pkg::xbit_fill_req_t   fill,
  output xbit_types_pkg::xbit_lookup_rsp_t rsp0,
  output xbit_types_pkg::xbit_lookup_rsp_t rsp1
);

  import xbit_cfg_pkg::*;
  import xbit_types_pkg::*;

  xbit_lookup_req_t   lookup0_q;
  xbit_lookup_req_t   lookup1_q;
  xbit_update_req_t   update_q;
  xbit_fill_req_t     fill_q;
  logic [INDEX_W-1:0] rmw_index;
  xbit_wr_cmd_t       wr_cmd;

  xbit_row_u          even0_row;
  xbit_row_u          even1_row;
  xbit_row_u          even_rmw_row;
  xbit_row_u          odd0_row;
  xbit_row_u          odd1_row;
  xbit_row_u          odd_rmw_row;
  logic               even0_perr;
  logic               even1_perr;
  logic               odd0_perr;
  logic               odd1_perr;

  xbit_req_stage u_req_stage (
    .clk       (clk),
    .rst       (rst),
    .lookup0   (lookup0),
    .lookup1   (lookup1),
    .update    (update),
    .fill      (fill),
    .lookup0_q (lookup0_q),
    .lookup1_q (lookup1_q),
    .update_q  (update_q),
    .fill_q    (fill_q)
  );

  xbit_bank_ram u_bank_even (
    .clk       (clk),
    .side      (1'b0),
    .rd0_index (lookup0_q.index),
    .rd1_index (lookup1_q.index),
    .rmw_index (rmw_index),
    .rd0_row   (even0_row),
    .rd1_row   (even1_row),
    .rmw_row   (even_rmw_row),
    .rd0_perr  (even0_perr),
    .rd1_perr  (even1_perr),
    .wr        (wr_cmd)
  );

  xbit_bank_ram u_bank_odd (
    .clk       (clk),
    .side      (1'b1),
    .rd0_index (lookup0_q.index),
    .rd1_index (lookup1_q.index),
    .rmw_index (rmw_index),
    .rd0_row   (odd0_row),
    .rd1_row   (odd1_row),
    .rmw_row   (odd_rmw_row),
    .rd0_perr  (odd0_perr),
    .rd1_perr  (odd1_perr),
    .wr        (wr_cmd)
  );

  xbit_merge_stage u_merge_stage (
    .update_q  (update_q),
    .fill_q    (fill_q),
    .even_row  (even_rmw_row),
    .odd_row   (odd_rmw_row),
    .rmw_index (rmw_index),
    .wr        (wr_cmd)
  );

  xbit_read_stage u_read_stage (
    .lookup0_q  (lookup0_q),
    .lookup1_q  (lookup1_q),
    .even0_row  (even0_row),
    .odd0_row   (odd0_row),
    .even1_row  (even1_row),
    .odd1_row   (odd1_row),
    .even0_perr (even0_perr),
    .odd0_perr  (odd0_perr),
    .even1_perr (even1_perr),
    .odd1_perr  (odd1_perr),
    .rsp0       (rsp0),
    .rsp1       (rsp1)
  );

endmodule

// File: verif/tb_clk_gen.sv
// Free-running 20 ns clock, reset held high over the first two rising edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;  // Released at the falling edge after the second rising edge
  end

  always #10 clk = ~clk;

endmodule

// File: verif/xbit_store_checker.sv
// Bound into the store top, the assertions only fire when the simulator evaluates assertions
`timescale 1ns/1ps

module xbit_store_checker (
  input logic                             clk,
  input logic                             rst,
  input xbit_types_pkg::xbit_lookup_req_t lookup0,
  input xbit_types_pkg::xbit_lookup_req_t lookup1,
  input xbit_types_pkg::xbit_update_req_t update,
  input xbit_types_pkg::xbit_fill_req_t   fill,
  input xbit_types_pkg::xbit_wr_cmd_t     wr_cmd,
  input xbit_types_pkg::xbit_lookup_rsp_t rsp0,
  input xbit_types_pkg::xbit_lookup_rsp_t rsp1
);

  // Update and fill share the one RMW path
  update_fill_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(update.en && fill.en))
    else $error("update and fill strobed in the same cycle");

  wr_idle_after_reset: assert property (@(posedge clk) rst |=> !wr_cmd.en)
    else $error("write command enabled in the cycle after reset");

  rsp0_follows_lookup: assert property (@(posedge clk) disable iff (rst)
    rsp0.valid |-> $past(lookup0.en))
    else $error("rsp0 valid without a lookup0 request one cycle earlier");

  rsp1_follows_lookup: assert property (@(posedge clk) disable iff (rst)
    rsp1.valid |-> $past(lookup1.en))
    else $error("rsp1 valid without a lookup1 request one cycle earlier");

endmodule

bind xbit_store_top xbit_store_checker u_checker (
  .clk     (clk),
  .rst     (rst),
  .lookup0 (lookup0),
  .lookup1 (lookup1),
  .update  (update),
  .fill    (fill),
  .wr_cmd  (wr_cmd),
  .rsp0    (rsp0),
  .rsp1    (rsp1)
);

// File: verif/xbit_store_tb.sv
// Directed and seeded random tests against an entry model, the first mismatch ends the run
`timescale 1ns/1ps

module xbit_store_tb;

  import xbit_cfg_pkg::*;
  import xbit_types_pkg::*;

  localparam int RESET_LIMIT   = 20;
  localparam int RANDOM_CYCLES = 300;

  logic             clk;
  logic             rst;
  xbit_lookup_req_t lookup0;
  xbit_lookup_req_t lookup1;
  xbit_update_req_t update;
  xbit_fill_req_t   fill;
  xbit_lookup_rsp_t rsp0;
  xbit_lookup_rsp_t rsp1;

  logic [ENTRY_W-1:0] model_even [ROWS][ENTRIES];
  logic [ENTRY_W-1:0] model_odd  [ROWS][ENTRIES];

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  xbit_store_top UUT (
    .clk     (clk),
    .rst     (rst),
    .lookup0 (lookup0),
    .lookup1 (lookup1),
    .update  (update),
    .fill    (fill),
    .rsp0    (rsp0),
    .rsp1    (rsp1)
  );

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    assert (got == exp) else begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [ENTRY_W-1:0] model_get(input logic odd,
                                                   input logic [INDEX_W-1:0] index,
                                                   input logic [SLOT_W-1:0] slot);
    return odd ? model_odd[index][slot] : model_even[index][slot];
  endfunction

  task automatic model_put(input logic odd, input logic [INDEX_W-1:0] index,
                           input logic [SLOT_W-1:0] slot, input logic [ENTRY_W-1:0] value);
    if (odd) begin
      model_odd[index][slot] = value;
    end else begin
      model_even[index][slot] = value;
    end
  endtask

  // Entry 8h+k of the row takes data bits 2k+1:2k
  task automatic model_fill(input xbit_fill_req_t f);
    logic [SLOT_W-1:0] slot;
    for (int k = 0; k < ENTRIES / 2; k++) begin
      slot = {f.half, k[2:0]};
      model_put(f.odd, f.index, slot, f.data[2*k +: 2]);
    end
  endtask

  function automatic logic [HALF_W-1:0] fill_pattern(input logic odd,
                                                     input logic [INDEX_W-1:0] index,
                                                     input logic half);
    return {index, odd, half, index ^ 5'h0b, 4'h6};
  endfunction

  function automatic xbit_lookup_req_t make_lookup(input logic en, input logic odd,
                                                   input logic [INDEX_W-1:0] index,
                                                   input logic [SLOT_W-1:0] slot);
    xbit_lookup_req_t r;
    r.en    = en;
    r.odd   = odd;
    r.index = index;
    r.slot  = slot;
    return r;
  endfunction

  function automatic xbit_update_req_t make_update(input logic odd,
                                                   input logic [INDEX_W-1:0] index,
                                                   input logic [SLOT_W-1:0] slot,
                                                   input logic [ENTRY_W-1:0] value);
    xbit_update_req_t r;
    r.en    = 1'b1;
    r.odd   = odd;
    r.index = index;
    r.slot  = slot;
    r.value = value;
    return r;
  endfunction

  function automatic xbit_fill_req_t make_fill(input logic odd, input logic [INDEX_W-1:0] index,
                                               input logic half, input logic [HALF_W-1:0] data);
    xbit_fill_req_t r;
    r.en    = 1'b1;
    r.odd   = odd;
    r.index = index;
    r.half  = half;
    r.data  = data;
    return r;
  endfunction

  task automatic check_rsp(input xbit_lookup_req_t req, input xbit_lookup_rsp_t rsp,
                           input string port);
    string where;
    where = $sformatf("%s bank %0d row %0d slot %0d", port, req.odd, req.index, req.slot);
    check_value(int'(rsp.valid), int'(req.en), {where, " valid"});
    if (req.en) begin
      check_value(int'(rsp.value), int'(model_get(req.odd, req.index, req.slot)),
                  {where, " value"});
      check_value(int'(rsp.parity_err), 0, {where, " parity_err"});
    end
  endtask

  // Responses are checked before this cycle's write reaches the model
  task automatic run_cycle(input xbit_lookup_req_t lk0, input xbit_lookup_req_t lk1,
                           input xbit_update_req_t upd, input xbit_fill_req_t fil);
    lookup0 = lk0;
    lookup1 = lk1;
    update  = upd;
    fill    = fil;
    @(negedge clk);
    check_rsp(lk0, rsp0, "rsp0");
    check_rsp(lk1, rsp1, "rsp1");
    if (upd.en) begin
      model_put(upd.odd, upd.index, upd.slot, upd.value);
    end
    if (fil.en) begin
      model_fill(fil);
    end
  endtask

  task automatic test_idle_after_reset();
    for (int c = 0; c < 10; c++) begin
      run_cycle('0, '0, '0, '0);
    end
  endtask

  task automatic test_fill_all();
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < ROWS; i++) begin
        for (int h = 0; h < 2; h++) begin
          run_cycle('0, '0, '0,
                    make_fill(o[0], i[INDEX_W-1:0], h[0],
                              fill_pattern(o[0], i[INDEX_W-1:0], h[0])));
        end
      end
    end
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < ROWS; i++) begin
        for (int s = 0; s < ENTRIES; s++) begin
          run_cycle(make_lookup(1'b1, o[0], i[INDEX_W-1:0], s[SLOT_W-1:0]),
                    make_lookup(1'b1, !o[0], i[INDEX_W-1:0], ~s[SLOT_W-1:0]), '0, '0);
        end
      end
    end
  endtask

  task automatic test_update_isolation();
    logic [ENTRY_W-1:0] new_val;
    new_val = ~model_get(1'b1, 5'd9, 4'd6);
    run_cycle('0, '0, make_update(1'b1, 5'd9, 4'd6, new_val), '0);
    for (int s = 0; s < ENTRIES; s++) begin
      run_cycle(make_lookup(1'b1, 1'b1, 5'd9, s[SLOT_W-1:0]),
                make_lookup(1'b1, 1'b0, 5'd9, s[SLOT_W-1:0]), '0, '0);
    end
  endtask

  task automatic test_ordering();
    logic [ENTRY_W-1:0] old_val;
    logic [ENTRY_W-1:0] new_val;
    logic [ENTRY_W-1:0] burst_val [4];
    xbit_lookup_req_t   lk;
    old_val = model_get(1'b0, 5'd20, 4'd3);
    new_val = old_val ^ 2'b01;
    lk      = make_lookup(1'b1, 1'b0, 5'd20, 4'd3);
    run_cycle(lk, '0, make_update(1'b0, 5'd20, 4'd3, new_val), '0);
    check_value(int'(rsp0.value), int'(old_val), "lookup beside its update");
    run_cycle(lk, '0, '0, '0);
    check_value(int'(rsp0.value), int'(new_val), "lookup after its update");
    for (int s = 0; s < 4; s++) begin
      burst_val[s] = ~model_get(1'b1, 5'd12, {s[1:0], 2'b01});  // Every write is visible
    end
    for (int s = 0; s < 4; s++) begin
      run_cycle('0, '0, make_update(1'b1, 5'd12, {s[1:0], 2'b01}, burst_val[s]), '0);
    end
    for (int s = 0; s < 4; s++) begin
      run_cycle(make_lookup(1'b1, 1'b1, 5'd12, {s[1:0], 2'b01}), '0, '0, '0);
      check_value(int'(rsp0.value), int'(burst_val[s]), "back-to-back update");
    end
  endtask

  task automatic test_random_traffic();
    int unsigned      r;
    xbit_lookup_req_t lk0;
    xbit_lookup_req_t lk1;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      r   = $urandom();
      lk0 = make_lookup(r[0], r[1], {2'b00, r[4:2]}, r[8:5]);  // Few rows, so hits collide
      lk1 = make_lookup(r[9], r[10], {2'b00, r[13:11]}, r[17:14]);
      r   = $urandom();
      if (r[0]) begin
        run_cycle(lk0, lk1, make_update(r[1], {2'b00, r[4:2]}, r[8:5], r[10:9]), '0);
      end else begin
        run_cycle(lk0, lk1, '0, make_fill(r[1], {2'b00, r[4:2]}, r[11], r[31:16]));
      end
    end
    run_cycle('0, '0, '0, '0);
  endtask

  initial begin
    int wait_count;
    void'($urandom(66));
    lookup0    = '0;
    lookup1    = '0;
    update     = '0;
    fill       = '0;
    wait_count = 0;
    @(negedge clk);
    while (rst && wait_count < RESET_LIMIT) begin
      @(negedge clk);
      wait_count++;
    end
    if (rst) begin
      $display("Timed out waiting for reset to be released");
      abort_run();
    end
    test_idle_after_reset();
    test_fill_all();
    test_update_isolation();
    test_ordering();
    test_random_traffic();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: build.f
common/xbit_cfg_pkg.sv
common/xbit_types_pkg.sv
xbit_bank/xbit_bank_ram.sv
hdl/xbit_req_stage.sv
hdl/xbit_merge_stage.sv
hdl/xbit_read_stage.sv
hdl/xbit_store_top.sv
verif/tb_clk_gen.sv
verif/xbit_store_checker.sv
verif/xbit_store_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module xbit_store_tb -f build.f -o xbit_store_sim

# A failing run exits non-zero, the log decides the result below
./obj_dir/xbit_store_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL: pass message not found in sim.log"
  exit 1
fi
